/* cache_cfg.svh */
// ##########################################################
// cache geometry macros
// index width, word address width, line and way counts
// ##########################################################
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

`define CACHE_INDEX_BITS     6
`define CACHE_SETS           (1 << `CACHE_INDEX_BITS)
`define CACHE_ADDR_BITS      25
`define CACHE_OFFSET_BITS    2
`define CACHE_WORDS_PER_LINE 4
`define CACHE_WAYS           4

`endif

/* cache_pkg.sv */
// ##########################################################
// cache types
// data and address vectors, request structs, way status,
// control FSM states
// ##########################################################
`include "cache_cfg.svh"

package cache_pkg;

    typedef logic [31:0]                                 word_t;
    typedef logic [`CACHE_WORDS_PER_LINE*32-1:0]         line_t;
    typedef logic [3:0]                                  byte_en_t;
    typedef logic [`CACHE_ADDR_BITS-1:0]                 word_addr_t;
    typedef logic [`CACHE_ADDR_BITS-`CACHE_OFFSET_BITS-1:0] line_addr_t;
    typedef logic [`CACHE_INDEX_BITS-1:0]                index_t;
    typedef logic [`CACHE_ADDR_BITS-`CACHE_OFFSET_BITS-`CACHE_INDEX_BITS-1:0] tag_t;
    typedef logic [`CACHE_OFFSET_BITS-1:0]               word_sel_t;
    typedef logic [`CACHE_WAYS-1:0]                      way_mask_t;
    typedef logic [1:0]                                  way_idx_t;
    typedef logic [2:0]                                  plru_t;

    typedef struct packed {
        word_addr_t addr;
        byte_en_t   byte_en;
        word_t      wdata;
        logic       read;
        logic       write;
    } cpu_req_t;

    typedef struct packed {
        line_addr_t line_addr;
        line_t      wdata;
        logic       read;
        logic       write;
    } mem_req_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
        logic dirty;
    } way_status_t;

    typedef enum logic [2:0] {
        IDLE, COMP, HIT_WR, FETCH_REQ, FETCH_WAIT, MERGE, WB_REQ, WB_WAIT
    } cache_state_e;

endpackage

/* cache_way.sv */
// ##########################################################
// one cache way
// tag store with valid and dirty flags per set
// line store with byte-enabled word writes and line fills
// ##########################################################
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_way
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  index_t      i_index,
    input  tag_t        i_tag,
    input  logic        i_write,
    input  logic        i_fill,
    input  line_t       i_line,
    input  byte_en_t    i_byte_en,
    input  word_sel_t   i_word_sel,
    output way_status_t o_status,
    output line_t       o_line
);

    tag_t                             tag_mem [`CACHE_SETS];
    line_t                            data_mem [`CACHE_SETS];
    logic [`CACHE_SETS-1:0]           valid_bits;
    logic [`CACHE_SETS-1:0]           dirty_bits;
    logic [`CACHE_WORDS_PER_LINE*4-1:0] byte_we;
    tag_t                             tag_q;
    logic                             valid_q;
    logic                             dirty_q;

    // a fill writes every byte, otherwise only the selected word
    always_comb begin
        for (int w = 0; w < `CACHE_WORDS_PER_LINE; w++) begin
            for (int b = 0; b < 4; b++) begin
                byte_we[w*4+b] = i_write &&
                                 (i_fill || (i_word_sel == word_sel_t'(w) && i_byte_en[b]));
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `CACHE_WORDS_PER_LINE*4; k++) begin
            if (byte_we[k]) data_mem[i_index][k*8 +: 8] <= i_line[k*8 +: 8];
        end
        if (i_write) tag_mem[i_index] <= i_tag;
        o_line <= data_mem[i_index];
        tag_q  <= tag_mem[i_index];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;   // whole way invalid in one cycle
            dirty_bits <= '0;
            valid_q    <= 1'b0;
            dirty_q    <= 1'b0;
        end else begin
            if (i_write) begin
                valid_bits[i_index] <= 1'b1;
                dirty_bits[i_index] <= !i_fill; // clean fill, dirty on store
            end
            valid_q <= valid_bits[i_index];
            dirty_q <= dirty_bits[i_index];
        end
    end

    assign o_status = '{tag: tag_q, valid: valid_q, dirty: dirty_q};

endmodule

/* cache_plru.sv */
// ##########################################################
// pseudo-LRU tree per set, 4 ways
// registered tree read, victim choice, update on access
// ##########################################################
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_plru
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  index_t   i_index,
    input  logic     i_update,
    input  way_idx_t i_way,
    output way_idx_t o_replace
);

    plru_t tree_mem [`CACHE_SETS];
    plru_t tree_q;
    plru_t tree_next;

    // bit 0 picks the half, bit 1 within ways 0-1, bit 2 within ways 2-3
    assign o_replace = tree_q[0] ? {1'b1, tree_q[2]} : {1'b0, tree_q[1]};

    always_comb begin
        tree_next    = tree_q;
        tree_next[0] = !i_way[1];           // away from the accessed half
        if (i_way[1]) begin
            tree_next[2] = !i_way[0];       // toward the sibling
        end else begin
            tree_next[1] = !i_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree_mem[s] <= '0;
            end
            tree_q <= '0;
        end else begin
            if (i_update) tree_mem[i_index] <= tree_next;
            tree_q <= tree_mem[i_index];
        end
    end

endmodule

/* cache_decode.sv */
// ##########################################################
// address split, tag compare and victim choice
// invalid ways win over the tree, lowest number first
// ##########################################################
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_decode
    import cache_pkg::*;
(
    input  cpu_req_t    i_req,
    input  way_status_t i_status [`CACHE_WAYS],
    input  way_idx_t    i_replace,
    output index_t      o_index,
    output tag_t        o_tag,
    output word_sel_t   o_word_sel,
    output way_mask_t   o_hit_mask,
    output way_idx_t    o_hit_way,
    output way_mask_t   o_victim_mask,
    output logic        o_victim_dirty,
    output line_addr_t  o_victim_line_addr
);

    way_idx_t victim;

    assign {o_tag, o_index, o_word_sel} = i_req.addr;

    always_comb begin
        o_hit_way = '0;
        victim    = i_replace;
        // descending so the lowest match is the one kept
        for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
            o_hit_mask[w] = i_status[w].valid && (i_status[w].tag == o_tag);
            if (o_hit_mask[w]) o_hit_way = way_idx_t'(w);
            if (!i_status[w].valid) victim = way_idx_t'(w);
        end
    end

    assign o_victim_mask      = way_mask_t'(1 << victim);
    assign o_victim_dirty     = i_status[victim].valid && i_status[victim].dirty;
    assign o_victim_line_addr = {i_status[victim].tag, o_index};

endmodule

/* cache_execute.sv */
// ##########################################################
// cache control FSM
// request hold, hit handling, dirty write-back, line fetch,
// fill and write merge, tree update strobes
// ##########################################################
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_execute
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  word_addr_t i_p_addr,
    input  byte_en_t   i_p_byte_en,
    input  word_t      i_p_wdata,
    input  logic       i_p_read,
    input  logic       i_p_write,
    input  way_mask_t  i_hit_mask,
    input  way_idx_t   i_hit_way,
    input  way_mask_t  i_victim_mask,
    input  logic       i_victim_dirty,
    input  line_addr_t i_victim_line_addr,
    input  line_t      i_wb_line,
    input  logic       i_m_rdata_valid,
    input  logic       i_m_waitrequest,
    output cpu_req_t   o_req,
    output way_mask_t  o_way_write,
    output logic       o_fill,
    output logic       o_plru_update,
    output way_idx_t   o_access_way,
    output logic       o_rd_hit,
    output logic       o_rd_fill,
    output logic       o_p_waitrequest,
    output mem_req_t   o_m_req
);

    cache_state_e state;
    cpu_req_t     req_in;
    cpu_req_t     req_q;
    way_mask_t    victim_q;
    way_idx_t     victim_way;
    line_addr_t   req_line;
    logic         accept;
    logic         any_hit;
    logic         fill_now;

    // read wins when both strobes are up
    assign req_in = '{addr: i_p_addr, byte_en: i_p_byte_en, wdata: i_p_wdata,
                      read: i_p_read, write: !i_p_read && i_p_write};

    assign accept     = (state == IDLE) && (i_p_read || i_p_write);
    assign o_req      = (state == IDLE) ? req_in : req_q;  // RAMs see the index a cycle early
    assign req_line   = req_q.addr[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS];
    assign any_hit    = |i_hit_mask;
    assign fill_now   = (state == FETCH_WAIT) && i_m_rdata_valid;
    assign victim_way = {victim_q[3] | victim_q[2], victim_q[3] | victim_q[1]};

    assign o_p_waitrequest = (state != IDLE);
    assign o_rd_hit        = (state == COMP) && any_hit && req_q.read;
    assign o_rd_fill       = fill_now && req_q.read;
    assign o_fill          = fill_now;
    assign o_plru_update   = ((state == COMP) && any_hit) || fill_now;
    assign o_access_way    = (state == COMP) ? i_hit_way : victim_way;

    always_comb begin
        o_way_write = '0;
        if (state == HIT_WR) begin
            o_way_write = i_hit_mask;
        end else if (fill_now || state == MERGE) begin
            o_way_write = victim_q;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) req_q <= req_in;
        if (state == COMP) victim_q <= i_victim_mask;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            o_m_req.read  <= 1'b0;
            o_m_req.write <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) state <= COMP;
                end
                COMP: begin
                    if (any_hit) begin
                        state <= req_q.write ? HIT_WR : IDLE;
                    end else if (i_victim_dirty) begin
                        state <= WB_REQ;
                    end else begin
                        o_m_req.read      <= 1'b1;
                        o_m_req.line_addr <= req_line;
                        state             <= FETCH_REQ;
                    end
                end
                HIT_WR: state <= IDLE;
                WB_REQ: begin
                    // victim line is on the way outputs now
                    o_m_req.write     <= 1'b1;
                    o_m_req.line_addr <= i_victim_line_addr;
                    o_m_req.wdata     <= i_wb_line;
                    state             <= WB_WAIT;
                end
                WB_WAIT: begin
                    if (!i_m_waitrequest) begin
                        o_m_req.write     <= 1'b0;
                        o_m_req.read      <= 1'b1;
                        o_m_req.line_addr <= req_line;
                        state             <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    if (!i_m_waitrequest) begin
                        o_m_req.read <= 1'b0;
                        state        <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (i_m_rdata_valid) state <= req_q.write ? MERGE : IDLE;
                end
                MERGE:   state <= IDLE;     // store word over the fresh line
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* cache_result.sv */
// ##########################################################
// read response and write-back line select
// word from hit way or memory line, registered with valid
// ##########################################################
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_result
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  line_t     i_way_line [`CACHE_WAYS],
    input  way_idx_t  i_hit_way,
    input  way_mask_t i_victim_mask,
    input  word_sel_t i_word_sel,
    input  logic      i_rd_hit,
    input  logic      i_rd_fill,
    input  line_t     i_m_rdata,
    output word_t     o_p_rdata,
    output logic      o_p_rdata_valid,
    output line_t     o_wb_line
);

    line_t src_line;

    assign src_line = i_rd_hit ? i_way_line[i_hit_way] : i_m_rdata;

    always_comb begin
        o_wb_line = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (i_victim_mask[w]) o_wb_line = i_way_line[w];  // one-hot
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_hit || i_rd_fill) o_p_rdata <= src_line[32*i_word_sel +: 32];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_p_rdata_valid <= 1'b0;
        end else begin
            o_p_rdata_valid <= i_rd_hit || i_rd_fill;
        end
    end

endmodule

/* cache_top.sv */
// ##########################################################
// 4-way write-back cache top level
// four ways, pseudo-LRU tree, decode, control FSM, result
// ##########################################################
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_top
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  word_addr_t i_p_addr,
    input  byte_en_t   i_p_byte_en,
    input  word_t      i_p_wdata,
    input  logic       i_p_read,
    input  logic       i_p_write,
    input  line_t      i_m_rdata,
    input  logic       i_m_rdata_valid,
    input  logic       i_m_waitrequest,
    output word_t      o_p_rdata,
    output logic       o_p_rdata_valid,
    output logic       o_p_waitrequest,
    output mem_req_t   o_m_req
);

    cpu_req_t    req;
    index_t      index;
    tag_t        tag;
    word_sel_t   word_sel;
    way_status_t status [`CACHE_WAYS];
    line_t       way_line [`CACHE_WAYS];
    way_mask_t   hit_mask;
    way_mask_t   victim_mask;
    way_mask_t   way_write;
    way_idx_t    hit_way;
    way_idx_t    replace;
    way_idx_t    access_way;
    line_addr_t  victim_line_addr;
    line_t       wb_line;
    line_t       wr_line;
    logic        victim_dirty;
    logic        fill;
    logic        plru_update;
    logic        rd_hit;
    logic        rd_fill;

    // fill takes the memory line, a store takes the word in every slot
    assign wr_line = fill ? i_m_rdata : {`CACHE_WORDS_PER_LINE{req.wdata}};

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        cache_way u_way (
            .clk        (clk),
            .rst        (rst),
            .i_index    (index),
            .i_tag      (tag),
            .i_write    (way_write[w]),
            .i_fill     (fill),
            .i_line     (wr_line),
            .i_byte_en  (req.byte_en),
            .i_word_sel (word_sel),
            .o_status   (status[w]),
            .o_line     (way_line[w])
        );
    end

    cache_plru u_plru (
        .clk       (clk),
        .rst       (rst),
        .i_index   (index),
        .i_update  (plru_update),
        .i_way     (access_way),
        .o_replace (replace)
    );

    cache_decode u_decode (
        .i_req              (req),
        .i_status           (status),
        .i_replace          (replace),
        .o_index            (index),
        .o_tag              (tag),
        .o_word_sel         (word_sel),
        .o_hit_mask         (hit_mask),
        .o_hit_way          (hit_way),
        .o_victim_mask      (victim_mask),
        .o_victim_dirty     (victim_dirty),
        .o_victim_line_addr (victim_line_addr)
    );

    cache_execute u_execute (
        .clk                (clk),
        .rst                (rst),
        .i_p_addr           (i_p_addr),
        .i_p_byte_en        (i_p_byte_en),
        .i_p_wdata          (i_p_wdata),
        .i_p_read           (i_p_read),
        .i_p_write          (i_p_write),
        .i_hit_mask         (hit_mask),
        .i_hit_way          (hit_way),
        .i_victim_mask      (victim_mask),
        .i_victim_dirty     (victim_dirty),
        .i_victim_line_addr (victim_line_addr),
        .i_wb_line          (wb_line),
        .i_m_rdata_valid    (i_m_rdata_valid),
        .i_m_waitrequest    (i_m_waitrequest),
        .o_req              (req),
        .o_way_write        (way_write),
        .o_fill             (fill),
        .o_plru_update      (plru_update),
        .o_access_way       (access_way),
        .o_rd_hit           (rd_hit),
        .o_rd_fill          (rd_fill),
        .o_p_waitrequest    (o_p_waitrequest),
        .o_m_req            (o_m_req)
    );

    cache_result u_result (
        .clk             (clk),
        .rst             (rst),
        .i_way_line      (way_line),
        .i_hit_way       (hit_way),
        .i_victim_mask   (victim_mask),
        .i_word_sel      (word_sel),
        .i_rd_hit        (rd_hit),
        .i_rd_fill       (rd_fill),
        .i_m_rdata       (i_m_rdata),
        .o_p_rdata       (o_p_rdata),
        .o_p_rdata_valid (o_p_rdata_valid),
        .o_wb_line       (wb_line)
    );

endmodule

/* tb_clk_gen.sv */
// ##########################################################
// testbench clock and synchronous reset
// ##########################################################
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* tb_mem_model.sv */
// ##########################################################
// line-wide memory model for the cache testbench
// random wait per request, pattern preload, read pulse
// ##########################################################
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tb_mem_model
    import cache_pkg::*;
#(
    parameter int LINES = 1024
) (
    input  logic       clk,
    input  logic       rst,
    input  mem_req_t   i_req,
    input  logic [3:0] i_max_wait,
    output line_t      o_rdata,
    output logic       o_rdata_valid,
    output logic       o_waitrequest
);

    localparam int AW = $clog2(LINES);

    line_t      lines [LINES];
    logic [3:0] wait_cnt;
    int         seed;
    int         r;

    initial begin
        seed          = 44684;
        wait_cnt      = '0;
        o_rdata       = '0;
        o_rdata_valid = 1'b0;
        for (int l = 0; l < LINES; l++) begin
            for (int w = 0; w < `CACHE_WORDS_PER_LINE; w++) begin
                lines[l][32*w +: 32] = (l * `CACHE_WORDS_PER_LINE + w) ^ 32'h5A5A_0000;
            end
        end
    end

    assign o_waitrequest = (i_req.read || i_req.write) && (wait_cnt != 0);

    // next wait is drawn while idle and on every completion
    always @(posedge clk) begin
        if (rst) begin
            wait_cnt      <= '0;
            o_rdata_valid <= 1'b0;
        end else begin
            o_rdata_valid <= 1'b0;
            if (o_waitrequest) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else begin
                r = ($random(seed) & 32'h7fff_ffff) % (i_max_wait + 1);
                wait_cnt <= r[3:0];
                if (i_req.write) lines[i_req.line_addr[AW-1:0]] <= i_req.wdata;
                if (i_req.read) begin
                    o_rdata       <= lines[i_req.line_addr[AW-1:0]];
                    o_rdata_valid <= 1'b1;
                end
            end
        end
    end

endmodule

/* cache_tb.sv */
// ##########################################################
// cache testbench top
// DUT, memory model, word reference array, directed tests,
// write-back monitor and watchdog
// ##########################################################
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tb
    import cache_pkg::*;
();

    localparam int PERIOD_NS  = 20;
    localparam int RST_CYCLES = 16;
    localparam int TAGS       = 16;     // tags touched by the tests
    localparam int REF_WORDS  = TAGS << (`CACHE_INDEX_BITS + `CACHE_OFFSET_BITS);
    localparam int RAND_OPS   = 60;
    localparam int ACCESSES   = 2 + 2 + 5 + 10 + 8 + RAND_OPS;
    localparam int MISS_BOUND = 32;     // dirty miss at the longest memory wait
    localparam int TIMEOUT    = 200;

    logic       clk;
    logic       rst;
    word_addr_t p_addr;
    byte_en_t   p_be;
    word_t      p_wdata;
    logic       p_read;
    logic       p_write;
    word_t      p_rdata;
    logic       p_rdata_valid;
    logic       p_waitreq;
    mem_req_t   m_req;
    line_t      m_rdata;
    logic       m_rdata_valid;
    logic       m_waitreq;
    logic [3:0] max_wait;

    word_t      ref_mem [REF_WORDS];
    line_addr_t wb_addr;
    line_t      wb_line;
    int         wb_count;
    int         seed;
    int         errors;
    int         mark;
    int         tests_run;
    int         tests_failed;

    tb_clk_gen #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(RST_CYCLES)) u_clk (.clk(clk), .rst(rst));

    tb_mem_model #(.LINES(TAGS << `CACHE_INDEX_BITS)) u_mem (
        .clk           (clk),
        .rst           (rst),
        .i_req         (m_req),
        .i_max_wait    (max_wait),
        .o_rdata       (m_rdata),
        .o_rdata_valid (m_rdata_valid),
        .o_waitrequest (m_waitreq)
    );

    cache_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .i_p_addr        (p_addr),
        .i_p_byte_en     (p_be),
        .i_p_wdata       (p_wdata),
        .i_p_read        (p_read),
        .i_p_write       (p_write),
        .i_m_rdata       (m_rdata),
        .i_m_rdata_valid (m_rdata_valid),
        .i_m_waitrequest (m_waitreq),
        .o_p_rdata       (p_rdata),
        .o_p_rdata_valid (p_rdata_valid),
        .o_p_waitrequest (p_waitreq),
        .o_m_req         (m_req)
    );

    // last line handed to memory
    always @(posedge clk) begin
        if (rst) begin
            wb_count <= 0;
        end else if (m_req.write && !m_waitreq) begin
            wb_addr  <= m_req.line_addr;
            wb_line  <= m_req.wdata;
            wb_count <= wb_count + 1;
        end
    end

    function automatic word_addr_t make_addr(input int tag, input int set, input int word);
        return word_addr_t'((tag << (`CACHE_INDEX_BITS + 2)) | (set << 2) | word);
    endfunction

    function automatic line_addr_t line_of(input int tag, input int set);
        return line_addr_t'((tag << `CACHE_INDEX_BITS) | set);
    endfunction

    // root points away from the used half, half bit at the sibling
    function automatic plru_t touch_tree(input plru_t t, input int way);
        plru_t n;
        n    = t;
        n[0] = (way < 2);
        if (way < 2) begin
            n[1] = (way == 0);
        end else begin
            n[2] = (way == 2);
        end
        return n;
    endfunction

    function automatic int pick_victim(input plru_t t);
        if (t[0]) return t[2] ? 3 : 2;
        return t[1] ? 1 : 0;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != mark) tests_failed++;
        $display("test %s: %s", name, (errors == mark) ? "ok" : "failed");
        mark = errors;
    endtask

    // lat is the edge of the read pulse, or the busy edges of a write
    task automatic cpu_access(input logic wr, input word_addr_t a, input byte_en_t be,
                              input word_t wdata, output word_t rdata, output int lat);
        int n;
        p_addr  <= a;
        p_be    <= be;
        p_wdata <= wdata;
        p_read  <= !wr;
        p_write <= wr;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (p_waitreq && n < TIMEOUT);
        p_read  <= 1'b0;
        p_write <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while ((wr ? p_waitreq : !p_rdata_valid) && lat < TIMEOUT);
        rdata = p_rdata;
        if (n >= TIMEOUT || lat >= TIMEOUT) begin
            $display("access at %h was never accepted or never completed", a);
            errors++;
        end
        if (wr) lat--;
    endtask

    task automatic read_check(input word_addr_t a, output int lat);
        word_t d;
        cpu_access(1'b0, a, 4'h0, '0, d, lat);
        check_val($sformatf("o_p_rdata @%h", a), d, ref_mem[a]);
    endtask

    task automatic write_ref(input word_addr_t a, input byte_en_t be, input word_t d,
                             output int lat);
        word_t rd;
        cpu_access(1'b1, a, be, d, rd, lat);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) ref_mem[a][8*b +: 8] = d[8*b +: 8];
        end
    endtask

    task automatic read_miss_then_hit();
        int lat;
        read_check(make_addr(1, 3, 2), lat);
        read_check(make_addr(1, 3, 2), lat);
        check_val("o_p_rdata_valid edge", lat, 2);
        end_test("read miss then hit");
    endtask

    task automatic partial_write_hit();
        int lat;
        write_ref(make_addr(1, 3, 2), 4'b0101, 32'hAABB_CCDD, lat);
        check_val("o_p_waitrequest cycles", lat, 2);
        read_check(make_addr(1, 3, 2), lat);
        end_test("partial write hit");
    endtask

    task automatic write_miss_merge();
        int lat;
        write_ref(make_addr(2, 5, 1), 4'hF, 32'h1234_5678, lat);
        for (int w = 0; w < 4; w++) begin
            read_check(make_addr(2, 5, w), lat);
        end
        end_test("write miss merge");
    endtask

    task automatic dirty_eviction();
        plru_t tree;
        int    vtag;
        int    base;
        int    lat;
        tree = '0;
        for (int t = 1; t <= 4; t++) begin
            write_ref(make_addr(t, 9, 0), 4'hF, 32'hD000_0000 + t, lat);
            tree = touch_tree(tree, t - 1);     // empty set fills in way order
        end
        vtag = pick_victim(tree) + 1;
        base = wb_count;
        write_ref(make_addr(5, 9, 0), 4'hF, 32'hD000_0005, lat);
        check_val("o_m_req.write count", wb_count, base + 1);
        check_val("o_m_req.line_addr", wb_addr, line_of(vtag, 9));
        for (int w = 0; w < 4; w++) begin
            check_val($sformatf("o_m_req.wdata word %0d", w), wb_line[32*w +: 32],
                      ref_mem[make_addr(vtag, 9, w)]);
        end
        for (int t = 1; t <= 5; t++) begin
            read_check(make_addr(t, 9, 0), lat);
        end
        end_test("dirty eviction");
    endtask

    task automatic plru_victim_order();
        int    order [3];
        plru_t tree;
        int    victim;
        int    base;
        int    lat;
        order = '{2, 0, 3};
        tree  = '0;
        for (int t = 1; t <= 4; t++) begin
            write_ref(make_addr(t, 12, 0), 4'hF, 32'hC000_0000 + t, lat);
            tree = touch_tree(tree, t - 1);
        end
        for (int i = 0; i < 3; i++) begin
            read_check(make_addr(order[i] + 1, 12, 0), lat);
            tree = touch_tree(tree, order[i]);
        end
        victim = pick_victim(tree);
        base   = wb_count;
        read_check(make_addr(5, 12, 0), lat);
        check_val("o_m_req.write count", wb_count, base + 1);
        check_val("o_m_req.line_addr", wb_addr, line_of(victim + 1, 12));
        end_test("plru victim order");
    endtask

    task automatic random_mix();
        logic [31:0] r;
        word_addr_t  a;
        word_t       d;
        int          lat;
        max_wait <= 4'd7;
        for (int i = 0; i < RAND_OPS; i++) begin
            r = $random(seed);
            d = $random(seed);
            a = make_addr(r[10:8], 20 + r[13:12], r[1:0]);
            if (r[16]) begin
                write_ref(a, (r[23:20] == 4'h0) ? 4'hF : r[23:20], d, lat);
            end else begin
                read_check(a, lat);
            end
        end
        max_wait <= 4'd2;
        end_test("random mix");
    endtask

    initial begin
        seed         = 44684;
        errors       = 0;
        mark         = 0;
        tests_run    = 0;
        tests_failed = 0;
        p_addr       = '0;
        p_be         = '0;
        p_wdata      = '0;
        p_read       = 1'b0;
        p_write      = 1'b0;
        max_wait     = 4'd2;
        for (int a = 0; a < REF_WORDS; a++) begin
            ref_mem[a] = a ^ 32'h5A5A_0000;
        end
        do @(posedge clk); while (rst);
        read_miss_then_hit();
        partial_write_hit();
        write_miss_merge();
        dirty_eviction();
        plru_victim_order();
        random_mix();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #((RST_CYCLES + ACCESSES * MISS_BOUND) * PERIOD_NS);
        $display("watchdog expired before the tests finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
cache_pkg.sv
cache_way.sv
cache_plru.sv
cache_decode.sv
cache_execute.sv
cache_result.sv
cache_top.sv
tb_clk_gen.sv
tb_mem_model.sv
cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - cache_way.sv
      - cache_plru.sv
      - cache_decode.sv
      - cache_execute.sv
      - cache_result.sv
      - cache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_mem_model.sv
      - cache_tb.sv
